/* build.f */
+incdir+rtl
rtl/ooo_core_pkg.sv
rtl/dispatch_unit.sv
rtl/exec_units.sv
rtl/reorder_buffer.sv
rtl/commit_unit.sv
rtl/ooo_core.sv
verification/tb_clock_gen.sv
verification/tb_ooo_core.sv

/* Makefile */
# Verilator build and run of the out-of-order core testbench

TOP := tb_ooo_core

all: run

obj_dir/V$(TOP): build.f rtl/*.sv rtl/*.svh verification/*.sv
	verilator --binary --timing -f build.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -F -q "*** TEST PASSED ***" sim.log

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module ooo_core

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

/* verification/tb_ooo_core.sv */
// Directed tests of the core through its Wishbone write port
// Commits are collected by a negedge monitor and checked in dispatch order
// Expected values come from the opcode rules, operands from an xorshift source

`include "ooo_core_settings.svh"

module tb_ooo_core
  import ooo_core_pkg::*;
();

  localparam int WRITE_LIMIT  = 200;
  localparam int COMMIT_LIMIT = 500;
  localparam int RUN_LIMIT    = 20000;

  logic         clock;
  logic         reset;
  logic         restart;
  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  inst_word_t   wb_dat_w;
  logic         wb_ack;
  areg_idx_t    reg_rd_idx;
  logic         commit_valid;
  logic         commit_wr_en;
  areg_idx_t    commit_dest;
  data_t        commit_data;
  logic [15:0]  completed_count;
  core_status_e status;
  data_t        reg_rd_data;

  int          errors;
  int          checks;
  int          tests;
  int          errors_at_start;
  string       cur_test;
  logic [31:0] rng_state;

  // Reference state
  data_t     model_regs [`OOO_AREG_COUNT];
  areg_idx_t exp_dest [$];
  data_t     exp_data [$];
  logic      exp_wr [$];
  logic      exp_has_data [$];   // Halt and illegal carry no result
  areg_idx_t got_dest [$];
  data_t     got_data [$];
  logic      got_wr [$];

  tb_clock_gen u_tb_clock_gen (
    .restart (restart),
    .clock   (clock),
    .reset   (reset)
  );

  ooo_core u_ooo_core (
    .clock           (clock),
    .reset           (reset),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_dat_w        (wb_dat_w),
    .wb_ack          (wb_ack),
    .reg_rd_idx      (reg_rd_idx),
    .commit_valid    (commit_valid),
    .commit_wr_en    (commit_wr_en),
    .commit_dest     (commit_dest),
    .commit_data     (commit_data),
    .completed_count (completed_count),
    .status          (status),
    .reg_rd_data     (reg_rd_data)
  );

  ////////////////////////////////////////////////////////////
  // Commit monitor, outputs are stable at the falling edge
  always @(negedge clock)
  begin
    if (!reset && commit_valid)
    begin
      got_dest.push_back(commit_dest);
      got_data.push_back(commit_data);
      got_wr.push_back(commit_wr_en);
    end
  end

  // Run limit
  initial
  begin
    repeat (RUN_LIMIT) @(posedge clock);
    $display("Simulation ran past %0d cycles without finishing", RUN_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus source and reference model
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Zero-extended operands, results wrap at the result width
  function automatic data_t model_result(input logic [3:0] op, input operand_t a,
                                         input operand_t b);
    data_t ea;
    data_t eb;
    ea = data_t'(a);
    eb = data_t'(b);
    case (op)
      4'd0:    return ea + eb;
      4'd1:    return ea - eb;
      4'd2:    return ea & eb;
      4'd3:    return ea * eb;
      default: return '0;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  task automatic check_data(input string what, input data_t exp, input data_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERR %s: %s expected %h actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_idx(input string what, input areg_idx_t exp, input areg_idx_t act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERR %s: %s expected %0d actual %0d", cur_test, what, exp, act);
    end
  endtask

  task automatic check_status(input string what, input core_status_e exp,
                              input core_status_e act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERR %s: %s expected %s actual %s", cur_test, what, exp.name(), act.name());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and bookkeeping helpers
  task automatic clear_model();
    for (int i = 0; i < `OOO_AREG_COUNT; i++)
      model_regs[i] = '0;
    exp_dest.delete();
    exp_data.delete();
    exp_wr.delete();
    exp_has_data.delete();
    got_dest.delete();
    got_data.delete();
    got_wr.delete();
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    while (reset !== 1'b0 && waited < 50)
    begin
      @(negedge clock);
      waited++;
    end
    if (reset !== 1'b0)
    begin
      errors++;
      $display("%s: reset never released", cur_test);
    end
    clear_model();
  endtask

  task automatic apply_reset();
    @(posedge clock);
    #1 restart = 1'b1;
    @(posedge clock);
    #1 restart = 1'b0;
    @(negedge clock);   // Reset is high again by now
    wait_reset_release();
  endtask

  // Master holds the strobe until ack or until the limit runs out
  task automatic write_word(input inst_word_t word, input int limit, output logic acked);
    int waited;
    acked  = 1'b0;
    waited = 0;
    @(posedge clock);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_dat_w = word;
    while (!acked && waited < limit)
    begin
      @(negedge clock);
      acked = wb_ack;
      waited++;
    end
    @(posedge clock);
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic send_op(input logic [3:0] op, input areg_idx_t dest, input operand_t a,
                         input operand_t b);
    inst_word_t word;
    logic       acked;
    logic       is_result;
    data_t      res;
    word      = {op, dest, 1'b0, a, b};
    is_result = (op <= 4'd3);
    res       = model_result(op, a, b);
    write_word(word, WRITE_LIMIT, acked);
    if (!acked)
    begin
      errors++;
      $display("%s: word %h was never acknowledged", cur_test, word);
    end
    else
    begin
      exp_dest.push_back(dest);
      exp_data.push_back(res);
      exp_wr.push_back(is_result && dest != '0);
      exp_has_data.push_back(is_result);
      if (is_result && dest != '0)
        model_regs[dest] = res;
    end
  endtask

  // Waits for every expected commit, then compares in order
  task automatic collect_commits();
    int waited;
    waited = 0;
    while (got_dest.size() < exp_dest.size() && waited < COMMIT_LIMIT)
    begin
      @(negedge clock);
      waited++;
    end
    if (got_dest.size() < exp_dest.size())
    begin
      errors++;
      $display("%s: only %0d of %0d commits arrived", cur_test, got_dest.size(),
               exp_dest.size());
    end
    while (exp_dest.size() > 0 && got_dest.size() > 0)
    begin
      check_idx("commit_dest", exp_dest.pop_front(), got_dest.pop_front());
      check_data("commit_wr_en", data_t'(exp_wr.pop_front()), data_t'(got_wr.pop_front()));
      if (exp_has_data.pop_front())
        check_data("commit_data", exp_data.pop_front(), got_data.pop_front());
      else
      begin
        void'(exp_data.pop_front());
        void'(got_data.pop_front());
      end
    end
    exp_dest.delete();
    exp_data.delete();
    exp_wr.delete();
    exp_has_data.delete();
  endtask

  task automatic read_reg(input areg_idx_t idx, output data_t val);
    @(posedge clock);
    #1 reg_rd_idx = idx;
    @(negedge clock);
    val = reg_rd_data;   // Combinational read port
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    errors_at_start = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == errors_at_start)
      $display("test %s: ok", cur_test);
    else
      $display("test %s: %0d errors", cur_test, errors - errors_at_start);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  task automatic test_reset_state();
    data_t val;
    begin_test("reset_state");
    @(negedge clock);
    check_data("wb_ack", '0, data_t'(wb_ack));
    check_data("commit_valid", '0, data_t'(commit_valid));
    check_data("completed_count", '0, data_t'(completed_count));
    check_status("status", status_running, status);
    read_reg(3'd3, val);
    check_data("register 3", '0, val);
    end_test();
  endtask

  task automatic test_alu_results();
    data_t val;
    begin_test("alu_results");
    for (int i = 1; i < 8; i++)
      send_op(4'(i % 3), areg_idx_t'(i), operand_t'(next_random()),
              operand_t'(next_random()));
    collect_commits();
    for (int i = 1; i < 8; i++)
    begin
      read_reg(areg_idx_t'(i), val);
      check_data($sformatf("register %0d", i), model_regs[i], val);
    end
    end_test();
  endtask

  // Adds finish ahead of the multiply, commits must not
  task automatic test_out_of_order();
    begin_test("out_of_order");
    send_op(4'd3, 3'd1, operand_t'(next_random()), operand_t'(next_random()));
    for (int i = 2; i < 5; i++)
      send_op(4'd0, areg_idx_t'(i), operand_t'(next_random()),
              operand_t'(next_random()));
    collect_commits();
    end_test();
  endtask

  task automatic test_back_pressure();
    logic [15:0] count_before;
    logic [31:0] r;
    begin_test("back_pressure");
    @(negedge clock);
    count_before = completed_count;
    for (int i = 0; i < 20; i++)
    begin
      r = next_random();
      send_op({2'b00, r[1:0]}, r[4:2], r[16:5], operand_t'(next_random()));
    end
    collect_commits();
    check_data("completed_count", data_t'(count_before + 16'd20), data_t'(completed_count));
    end_test();
  endtask

  task automatic test_zero_register();
    data_t val;
    begin_test("zero_register");
    send_op(4'd0, 3'd0, 12'hfff, 12'h001);
    send_op(4'd3, 3'd0, 12'h123, 12'h456);
    send_op(4'd1, 3'd0, 12'h010, 12'h020);
    collect_commits();
    read_reg(3'd0, val);
    check_data("register 0", '0, val);
    end_test();
  endtask

  task automatic test_halt_and_illegal();
    logic acked;
    begin_test("halt_and_illegal");
    send_op(4'd0, 3'd5, 12'h00a, 12'h00b);
    send_op(4'd15, 3'd2, '0, '0);
    collect_commits();
    check_status("status after halt", status_halted_on_halt, status);
    write_word({4'd0, 3'd1, 25'd7}, 20, acked);
    if (acked)
    begin
      errors++;
      $display("%s: a write was acknowledged after the halt", cur_test);
    end

    // Fresh core for the illegal opcode
    apply_reset();
    check_status("status after reset", status_running, status);
    send_op(4'd7, 3'd4, 12'h001, 12'h002);
    collect_commits();
    check_status("status after illegal", status_halted_on_illegal, status);
    write_word({4'd0, 3'd1, 25'd7}, 20, acked);
    if (acked)
    begin
      errors++;
      $display("%s: a write was acknowledged after the illegal opcode", cur_test);
    end
    end_test();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  initial
  begin
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_dat_w   = '0;
    reg_rd_idx = '0;
    restart    = 1'b0;
    rng_state  = 32'd94481;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    cur_test   = "startup";
    wait_reset_release();

    test_reset_state();
    test_alu_results();
    test_out_of_order();
    test_back_pressure();
    test_zero_register();
    test_halt_and_illegal();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* verification/tb_clock_gen.sv */
// Testbench clock with period 8 and a synchronous reset held for 10 cycles
// A one-cycle pulse on restart asserts reset again for another 10 cycles

module tb_clock_gen
(
  input  logic restart,
  output logic clock,
  output logic reset
);

  int unsigned cycles;
  logic        restart_seen;

  initial
  begin
    clock  = 1'b0;
    reset  = 1'b1;
    cycles = 0;
    forever #4 clock = ~clock;
  end

  // Reset changes just after the edge, like the other stimulus
  always @(posedge clock)
  begin
    restart_seen = restart;
    #1;
    if (restart_seen)
      cycles = 0;
    else if (cycles < 10)
      cycles = cycles + 1;
    reset = (cycles < 10);
  end

endmodule

/* rtl/ooo_core.sv */
// Scalar core with in-order dispatch, out-of-order completion and in-order commit
// Instructions arrive as write-only Wishbone words, operands are immediates

`include "ooo_core_settings.svh"

module ooo_core
  import ooo_core_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  inst_word_t   wb_dat_w,
  output logic         wb_ack,
  input  areg_idx_t    reg_rd_idx,
  output logic         commit_valid,
  output logic         commit_wr_en,
  output areg_idx_t    commit_dest,
  output data_t        commit_data,
  output logic [15:0]  completed_count,
  output core_status_e status,
  output data_t        reg_rd_data
);

  // Dispatch to ROB
  logic         alloc_valid;
  areg_idx_t    alloc_dest;
  retire_kind_e alloc_kind;
  rob_tag_t     alloc_tag;
  logic         rob_full;

  // Dispatch to execution
  logic         issue_valid;
  opcode_e      issue_op;
  operand_t     issue_a;
  operand_t     issue_b;
  rob_tag_t     issue_tag;

  // Result ports
  logic         alu_done;
  rob_tag_t     alu_tag;
  data_t        alu_data;
  logic         mul_done;
  rob_tag_t     mul_tag;
  data_t        mul_data;

  // ROB to commit
  logic         retire_valid;
  areg_idx_t    retire_dest;
  data_t        retire_data;
  retire_kind_e retire_kind;

  dispatch_unit u_dispatch_unit (
    .clock       (clock),
    .reset       (reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_dat_w    (wb_dat_w),
    .wb_ack      (wb_ack),
    .rob_full    (rob_full),
    .alloc_tag   (alloc_tag),
    .alloc_valid (alloc_valid),
    .alloc_dest  (alloc_dest),
    .alloc_kind  (alloc_kind),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag)
  );

  exec_units u_exec_units (
    .clock       (clock),
    .reset       (reset),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .issue_tag   (issue_tag),
    .alu_done    (alu_done),
    .alu_tag     (alu_tag),
    .alu_data    (alu_data),
    .mul_done    (mul_done),
    .mul_tag     (mul_tag),
    .mul_data    (mul_data)
  );

  reorder_buffer u_reorder_buffer (
    .clock        (clock),
    .reset        (reset),
    .alloc_valid  (alloc_valid),
    .alloc_dest   (alloc_dest),
    .alloc_kind   (alloc_kind),
    .alloc_tag    (alloc_tag),
    .rob_full     (rob_full),
    .alu_done     (alu_done),
    .alu_tag      (alu_tag),
    .alu_data     (alu_data),
    .mul_done     (mul_done),
    .mul_tag      (mul_tag),
    .mul_data     (mul_data),
    .retire_valid (retire_valid),
    .retire_dest  (retire_dest),
    .retire_data  (retire_data),
    .retire_kind  (retire_kind)
  );

  commit_unit u_commit_unit (
    .clock           (clock),
    .reset           (reset),
    .retire_valid    (retire_valid),
    .retire_dest     (retire_dest),
    .retire_data     (retire_data),
    .retire_kind     (retire_kind),
    .reg_rd_idx      (reg_rd_idx),
    .commit_valid    (commit_valid),
    .commit_wr_en    (commit_wr_en),
    .commit_dest     (commit_dest),
    .commit_data     (commit_data),
    .completed_count (completed_count),
    .status          (status),
    .reg_rd_data     (reg_rd_data)
  );

endmodule

/* rtl/commit_unit.sv */
// Architectural register file and commit status
// Takes the ROB head every cycle it is valid, outputs registered once
// Register zero is never written and reads as zero

`include "ooo_core_settings.svh"

module commit_unit
  import ooo_core_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         retire_valid,
  input  areg_idx_t    retire_dest,
  input  data_t        retire_data,
  input  retire_kind_e retire_kind,
  input  areg_idx_t    reg_rd_idx,
  output logic         commit_valid,
  output logic         commit_wr_en,
  output areg_idx_t    commit_dest,
  output data_t        commit_data,
  output logic [15:0]  completed_count,
  output core_status_e status,
  output data_t        reg_rd_data
);

  data_t regs_q [`OOO_AREG_COUNT];
  logic  wr_en;

  assign wr_en = retire_valid && (retire_kind == kind_result) && (retire_dest != '0);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      commit_valid    <= 1'b0;
      commit_wr_en    <= 1'b0;
      completed_count <= '0;
      status          <= status_running;
      for (int i = 0; i < `OOO_AREG_COUNT; i++)
        regs_q[i] <= '0;
    end
    else
    begin
      commit_valid <= retire_valid;
      commit_wr_en <= wr_en;
      if (wr_en)
        regs_q[retire_dest] <= retire_data;
      if (retire_valid)
        completed_count <= completed_count + 16'd1;   // Halt and illegal count too
      if (retire_valid && status == status_running)
      begin
        if (retire_kind == kind_halt)
          status <= status_halted_on_halt;
        else if (retire_kind == kind_illegal)
          status <= status_halted_on_illegal;
      end
    end
  end

  // Commit payload
  always_ff @(posedge clock)
  begin
    commit_dest <= retire_dest;
    commit_data <= retire_data;
  end

  assign reg_rd_data = regs_q[reg_rd_idx];   // Entry zero stays cleared

endmodule

/* rtl/reorder_buffer.sv */
// Circular reorder buffer, allocation at the tail and retirement at the head
// Allocation must not be requested while rob_full is high
// Head leaves every cycle it is done, one entry per cycle

`include "ooo_core_settings.svh"

module reorder_buffer
  import ooo_core_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         alloc_valid,
  input  areg_idx_t    alloc_dest,
  input  retire_kind_e alloc_kind,
  output rob_tag_t     alloc_tag,
  output logic         rob_full,
  input  logic         alu_done,
  input  rob_tag_t     alu_tag,
  input  data_t        alu_data,
  input  logic         mul_done,
  input  rob_tag_t     mul_tag,
  input  data_t        mul_data,
  output logic         retire_valid,
  output areg_idx_t    retire_dest,
  output data_t        retire_data,
  output retire_kind_e retire_kind
);

  localparam int DEPTH = `OOO_ROB_DEPTH;

  logic [DEPTH-1:0]           done_q;
  retire_kind_e               kind_q [DEPTH];
  areg_idx_t                  dest_q [DEPTH];
  data_t                      data_q [DEPTH];
  rob_tag_t                   head_q;
  rob_tag_t                   tail_q;
  logic [$clog2(DEPTH):0]     count_q;

  assign alloc_tag    = tail_q;
  assign rob_full     = (count_q == DEPTH);
  assign retire_valid = done_q[head_q];
  assign retire_dest  = dest_q[head_q];
  assign retire_data  = data_q[head_q];
  assign retire_kind  = kind_q[head_q];

  ////////////////////////////////////////////////////////////
  // Pointers, occupancy and done bits
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end
    else
    begin
      if (alloc_valid)
      begin
        tail_q         <= tail_q + rob_tag_t'(1);
        done_q[tail_q] <= (alloc_kind != kind_result);   // Nothing to wait for
      end
      if (retire_valid)
      begin
        head_q         <= head_q + rob_tag_t'(1);
        done_q[head_q] <= 1'b0;
      end
      // Result tags never match the head or the tail
      if (alu_done)
        done_q[alu_tag] <= 1'b1;
      if (mul_done)
        done_q[mul_tag] <= 1'b1;

      case ({alloc_valid, retire_valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Entry payload
  always_ff @(posedge clock)
  begin
    if (alloc_valid)
    begin
      kind_q[tail_q] <= alloc_kind;
      dest_q[tail_q] <= alloc_dest;
    end
    if (alu_done)
      data_q[alu_tag] <= alu_data;
    if (mul_done)
      data_q[mul_tag] <= mul_data;
  end

endmodule

/* rtl/exec_units.sv */
// One-cycle ALU and a fixed-latency multiplier, both never stall
// Results come back as single-cycle pulses tagged with the ROB entry

`include "ooo_core_settings.svh"

module exec_units
  import ooo_core_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     issue_valid,
  input  opcode_e  issue_op,
  input  operand_t issue_a,
  input  operand_t issue_b,
  input  rob_tag_t issue_tag,
  output logic     alu_done,
  output rob_tag_t alu_tag,
  output data_t    alu_data,
  output logic     mul_done,
  output rob_tag_t mul_tag,
  output data_t    mul_data
);

  localparam int STAGES = `OOO_MUL_STAGES;

  logic              issue_mul;
  data_t             ext_a;
  data_t             ext_b;
  logic [STAGES-1:0] mul_valid_q;
  rob_tag_t          mul_tag_q  [STAGES];
  data_t             mul_data_q [STAGES];

  assign issue_mul = issue_valid && (issue_op == op_mul);
  assign ext_a     = data_t'(issue_a);   // Zero-extended operands
  assign ext_b     = data_t'(issue_b);

  ////////////////////////////////////////////////////////////
  // ALU
  always_ff @(posedge clock)
  begin
    if (reset)
      alu_done <= 1'b0;
    else
      alu_done <= issue_valid && !issue_mul;
  end

  always_ff @(posedge clock)
  begin
    alu_tag <= issue_tag;
    case (issue_op)
      op_add:  alu_data <= ext_a + ext_b;
      op_sub:  alu_data <= ext_a - ext_b;   // Wraps at 24 bits
      default: alu_data <= ext_a & ext_b;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Multiplier shift pipeline
  always_ff @(posedge clock)
  begin
    if (reset)
      mul_valid_q <= '0;
    else
      mul_valid_q <= {mul_valid_q[STAGES-2:0], issue_mul};
  end

  always_ff @(posedge clock)
  begin
    mul_tag_q[0]  <= issue_tag;
    mul_data_q[0] <= ext_a * ext_b;   // Full product fits
    for (int i = 1; i < STAGES; i++)
    begin
      mul_tag_q[i]  <= mul_tag_q[i-1];
      mul_data_q[i] <= mul_data_q[i-1];
    end
  end

  assign mul_done = mul_valid_q[STAGES-1];
  assign mul_tag  = mul_tag_q[STAGES-1];
  assign mul_data = mul_data_q[STAGES-1];

endmodule

/* rtl/dispatch_unit.sv */
// Wishbone write-only slave that feeds the ROB and the execution units
// One word per ack, never two acks in a row
// After a halt or illegal word nothing is acknowledged until reset

`include "ooo_core_settings.svh"

module dispatch_unit
  import ooo_core_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  inst_word_t   wb_dat_w,
  output logic         wb_ack,
  input  logic         rob_full,
  input  rob_tag_t     alloc_tag,
  output logic         alloc_valid,
  output areg_idx_t    alloc_dest,
  output retire_kind_e alloc_kind,
  output logic         issue_valid,
  output opcode_e      issue_op,
  output operand_t     issue_a,
  output operand_t     issue_b,
  output rob_tag_t     issue_tag
);

  logic      stop_q;   // Sticky after halt or illegal
  logic      accept;
  logic [3:0] op_q;
  areg_idx_t dest_q;
  operand_t  a_q;
  operand_t  b_q;

  assign accept = wb_cyc && wb_stb && wb_we && !rob_full && !stop_q && !wb_ack;

  ////////////////////////////////////////////////////////////
  // Acknowledge and stop flag
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      wb_ack <= 1'b0;
      stop_q <= 1'b0;
    end
    else
    begin
      wb_ack <= accept;
      if (wb_ack && alloc_kind != kind_result)
        stop_q <= 1'b1;
    end
  end

  // Word fields latched with the ack
  always_ff @(posedge clock)
  begin
    if (accept)
    begin
      op_q   <= wb_dat_w[31:28];
      dest_q <= wb_dat_w[27:25];
      a_q    <= wb_dat_w[23:12];
      b_q    <= wb_dat_w[11:0];
    end
  end

  ////////////////////////////////////////////////////////////
  // Decode
  always_comb
  begin
    case (op_q)
      op_add, op_sub, op_and, op_mul: alloc_kind = kind_result;
      op_halt:                        alloc_kind = kind_halt;
      default:                        alloc_kind = kind_illegal;
    endcase
  end

  // Ack cycle is the dispatch cycle
  assign alloc_valid = wb_ack;
  assign alloc_dest  = dest_q;

  // Halt and illegal only occupy a ROB slot
  assign issue_valid = wb_ack && (alloc_kind == kind_result);
  assign issue_op    = opcode_e'(op_q);
  assign issue_a     = a_q;
  assign issue_b     = b_q;
  assign issue_tag   = alloc_tag;

endmodule

/* rtl/ooo_core_pkg.sv */
// Shared types of the core
// Opcode values outside the enum are illegal and stop the core

`include "ooo_core_settings.svh"

package ooo_core_pkg;

  typedef logic [`OOO_INST_WIDTH-1:0]            inst_word_t;
  typedef logic [`OOO_OPERAND_WIDTH-1:0]         operand_t;
  typedef logic [`OOO_DATA_WIDTH-1:0]            data_t;
  typedef logic [$clog2(`OOO_AREG_COUNT)-1:0]    areg_idx_t;
  typedef logic [$clog2(`OOO_ROB_DEPTH)-1:0]     rob_tag_t;

  // Instruction opcodes, bits 31:28 of the word
  typedef enum logic [3:0] {
    op_add  = 4'd0,
    op_sub  = 4'd1,
    op_and  = 4'd2,
    op_mul  = 4'd3,
    op_halt = 4'd15
  } opcode_e;

  // Commit state machine
  typedef enum logic [1:0] {
    status_running,
    status_halted_on_halt,
    status_halted_on_illegal
  } core_status_e;

  // What an entry does when it leaves the ROB
  typedef enum logic [1:0] {
    kind_result,
    kind_halt,
    kind_illegal
  } retire_kind_e;

endpackage

/* rtl/ooo_core_settings.svh */
// Widths, depths and latencies shared by the core and its testbench
// ROB depth must be a power of two, since the pointers wrap by overflow
// The multiplier pipeline needs at least two stages
`ifndef OOO_CORE_SETTINGS_SVH
`define OOO_CORE_SETTINGS_SVH

// Instruction word and operand widths
`define OOO_INST_WIDTH     32
`define OOO_OPERAND_WIDTH  12

// Result width holds a full 12 x 12 product
`define OOO_DATA_WIDTH     24

// Architectural registers, register zero reads as zero
`define OOO_AREG_COUNT     8

// Reorder buffer entries
`define OOO_ROB_DEPTH      8

// Multiplier latency in cycles
`define OOO_MUL_STAGES     4

`endif
